// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = peakSearchTb
LINT_TOP  = peakSearchTop
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a result"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/maxOf4.sv
`timescale 1ns/1ps
`default_nettype none

module maxOf4
(
   input  wire  logic                clk,
   input  wire  logic                rst,
   input  wire  peakPkg::candidate_t cand [0:3],
   output       peakPkg::candidate_t winner
);

   logic                selLow;     // input 1 beats input 0
   logic                selHigh;    // input 3 beats input 2
   logic                selFinal;   // high pair beats low pair
   peakPkg::candidate_t lowPair;
   peakPkg::candidate_t highPair;
   peakPkg::candidate_t best;

   // 1 when the later operand should win, so ties go to the later input
   function automatic logic takeLater
   (
      input peakPkg::value_t earlier,
      input peakPkg::value_t later
   );
      return later >= earlier;   // signed compare
   endfunction

   assign selLow  = takeLater(cand[0].value, cand[1].value);
   assign selHigh = takeLater(cand[2].value, cand[3].value);

   always_comb
   begin
      lowPair  = selLow  ? cand[1] : cand[0];
      highPair = selHigh ? cand[3] : cand[2];
   end

   // the high pair holds the later inputs, so an equal value goes to it
   assign selFinal = takeLater(lowPair.value, highPair.value);
   assign best     = selFinal ? highPair : lowPair;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         winner <= '0;
      end
      else
      begin
         winner <= best;   // one cycle latency, new set every cycle
      end
   end

   generate
      for (genvar i = 0; i < 4; i++)
      begin : g_check
         a_winnerNotSmaller : assert property (
            @(posedge clk) disable iff (rst)
            !$past(rst) |-> winner.value >= $past(cand[i].value)
         )
            else $error("maxOf4 winner %0d is below input %0d of the last cycle",
                        winner.value, i);
      end
   endgenerate

endmodule

`default_nettype wire

// File: rtl/peakCfg.sv
`timescale 1ns/1ps
`default_nettype none

module peakCfg
(
   input  wire  logic                              clk,
   input  wire  logic                              rst,
   input  wire  logic                              cfgWrite,
   input  wire  peakPkg::cfgAddr_e                 cfgAddr,
   input  wire  logic [peakPkg::cfgDataWidth-1:0]  cfgWdata,
   input  wire  logic [peakPkg::countWidth-1:0]    hitCount,
   output       logic [peakPkg::cfgDataWidth-1:0]  cfgRdata,
   output       peakPkg::value_t                   threshold,
   output       logic                              enable,
   output       logic                              clearCount
);

   logic writeThreshold;
   logic writeControl;

   assign writeThreshold = cfgWrite && (cfgAddr == peakPkg::addrThreshold);
   assign writeControl   = cfgWrite && (cfgAddr == peakPkg::addrControl);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         threshold <= '0;
         enable    <= 1'b1;   // detection on out of reset
      end
      else
      begin
         if (writeThreshold)
         begin
            threshold <= cfgWdata[peakPkg::valueWidth-1:0];
         end
         if (writeControl)
         begin
            enable <= cfgWdata[0];
         end
      end
   end

   // counter sees the clear on the write cycle and zeroes at the next edge
   assign clearCount = writeControl && cfgWdata[1];

   always_comb
   begin
      cfgRdata = '0;
      case (cfgAddr)
         peakPkg::addrThreshold:
         begin
            cfgRdata = {{(peakPkg::cfgDataWidth - peakPkg::valueWidth)
                         {threshold[peakPkg::valueWidth-1]}}, threshold};   // sign-extend
         end
         peakPkg::addrControl:
         begin
            cfgRdata[0] = enable;
         end
         peakPkg::addrHitCount:
         begin
            cfgRdata = hitCount;
         end
         default:
         begin
            cfgRdata = '0;   // unmapped address
         end
      endcase
   end

   a_noCountWrite : assert property (
      @(posedge clk) disable iff (rst)
      cfgWrite |-> cfgAddr != peakPkg::addrHitCount
   )
      else $error("write to read-only hit counter");

endmodule

`default_nettype wire

// File: rtl/peakDetect.sv
`timescale 1ns/1ps
`default_nettype none

module peakDetect
(
   input  wire  logic                            clk,
   input  wire  logic                            rst,
   input  wire  peakPkg::candidate_t             treePeak,
   input  wire  logic                            treeValid,
   input  wire  peakPkg::value_t                 threshold,
   input  wire  logic                            enable,
   input  wire  logic                            clearCount,
   output       peakPkg::peak_t                  peak,
   output       logic                            peakValid,
   output       logic [peakPkg::countWidth-1:0]  hitCount
);

   logic isHit;
   logic countFull;

   // strictly above, both operands signed
   assign isHit     = enable && (treePeak.value > threshold);
   assign countFull = &hitCount;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         peakValid <= 1'b0;
      end
      else
      begin
         peakValid <= treeValid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (treeValid)
      begin
         peak.value <= treePeak.value;
         peak.index <= treePeak.index;
         peak.hit   <= isHit;
      end
   end

   // counts with the same edge that raises peakValid
   always_ff @(posedge clk)
   begin
      if (rst || clearCount)
      begin
         hitCount <= '0;   // clear beats a hit in the same cycle
      end
      else if (treeValid && isHit && !countFull)
      begin
         hitCount <= hitCount + 1'b1;
      end
   end

   a_noStrayValid : assert property (
      @(posedge clk) disable iff (rst)
      peakValid && $past(peakValid) |-> $past(treeValid) && $past(treeValid, 2)
   )
      else $error("peakValid held without two cycles of treeValid");

endmodule

`default_nettype wire

// File: rtl/peakPkg.sv
`default_nettype none

package peakPkg;

   localparam int valueWidth   = 12;   // signed correlator magnitude
   localparam int numBins      = 16;   // parallel correlator outputs
   localparam int indexWidth   = 4;    // log2 of numBins
   localparam int countWidth   = 16;   // hit counter
   localparam int cfgDataWidth = 16;   // register port data

   typedef logic signed [valueWidth-1:0] value_t;

   // one correlator output tagged with the bin it came from
   typedef struct packed {
      value_t                value;
      logic [indexWidth-1:0] index;
   } candidate_t;

   // detected peak as seen at the top level
   typedef struct packed {
      value_t                value;
      logic [indexWidth-1:0] index;
      logic                  hit;     // above threshold with enable set
   } peak_t;

   typedef enum logic [1:0] {
      addrThreshold = 2'd0,   // read/write
      addrControl   = 2'd1,   // bit 0 enable, bit 1 clear pulse
      addrHitCount  = 2'd2    // read only
   } cfgAddr_e;

endpackage

`default_nettype wire

// File: rtl/peakSearchTop.sv
`timescale 1ns/1ps
`default_nettype none

module peakSearchTop
(
   input  wire  logic                                    clk,
   input  wire  logic                                    rst,
   input  wire  peakPkg::value_t [peakPkg::numBins-1:0]  samples,
   input  wire  logic                                    sampleValid,
   input  wire  logic                                    cfgWrite,
   input  wire  peakPkg::cfgAddr_e                       cfgAddr,
   input  wire  logic [peakPkg::cfgDataWidth-1:0]        cfgWdata,
   output       logic [peakPkg::cfgDataWidth-1:0]        cfgRdata,
   output       peakPkg::peak_t                          peak,
   output       logic                                    peakValid
);

   peakPkg::candidate_t               treePeak;
   logic                              treeValid;
   peakPkg::value_t                   threshold;
   logic                              enable;
   logic                              clearCount;
   logic [peakPkg::countWidth-1:0]    hitCount;

   peakTree u_peakTree
   (
      .clk         (clk),
      .rst         (rst),
      .samples     (samples),
      .sampleValid (sampleValid),
      .treePeak    (treePeak),
      .treeValid   (treeValid)
   );

   peakDetect u_peakDetect
   (
      .clk        (clk),
      .rst        (rst),
      .treePeak   (treePeak),
      .treeValid  (treeValid),
      .threshold  (threshold),
      .enable     (enable),
      .clearCount (clearCount),
      .peak       (peak),
      .peakValid  (peakValid),
      .hitCount   (hitCount)
   );

   peakCfg u_peakCfg
   (
      .clk        (clk),
      .rst        (rst),
      .cfgWrite   (cfgWrite),
      .cfgAddr    (cfgAddr),
      .cfgWdata   (cfgWdata),
      .hitCount   (hitCount),
      .cfgRdata   (cfgRdata),
      .threshold  (threshold),
      .enable     (enable),
      .clearCount (clearCount)
   );

endmodule

`default_nettype wire

// File: rtl/peakTree.sv
`timescale 1ns/1ps
`default_nettype none

module peakTree
(
   input  wire  logic                                       clk,
   input  wire  logic                                       rst,
   input  wire  peakPkg::value_t [peakPkg::numBins-1:0]     samples,
   input  wire  logic                                       sampleValid,
   output       peakPkg::candidate_t                        treePeak,
   output       logic                                       treeValid
);

   peakPkg::candidate_t stage1In  [0:peakPkg::numBins/4-1][0:3];
   peakPkg::candidate_t stage1Win [0:peakPkg::numBins/4-1];
   logic [1:0]          validPipe;   // one bit per tree stage

   // tag every sample with its bin position
   always_comb
   begin
      for (int g = 0; g < peakPkg::numBins / 4; g++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            stage1In[g][k].value = samples[4 * g + k];
            stage1In[g][k].index = peakPkg::indexWidth'(4 * g + k);
         end
      end
   end

   generate
      for (genvar g = 0; g < peakPkg::numBins / 4; g++)
      begin : g_stage1
         maxOf4 u_maxOf4
         (
            .clk    (clk),
            .rst    (rst),
            .cand   (stage1In[g]),
            .winner (stage1Win[g])
         );
      end
   endgenerate

   // groups are in bin order, so the later-wins tie rule keeps the highest bin
   maxOf4 u_stage2
   (
      .clk    (clk),
      .rst    (rst),
      .cand   (stage1Win),
      .winner (treePeak)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         validPipe <= '0;
      end
      else
      begin
         validPipe <= {validPipe[0], sampleValid};
      end
   end

   assign treeValid = validPipe[1];

   a_validAligned : assert property (
      @(posedge clk) disable iff (rst)
      !$past(rst) && !$past(rst, 2) |-> treeValid == $past(sampleValid, 2)
   )
      else $error("treeValid out of step with sampleValid");

endmodule

`default_nettype wire

// File: verif/peakSearchTb.sv
`timescale 1ns/1ps
`default_nettype none

module peakSearchTb;

   typedef peakPkg::value_t [peakPkg::numBins-1:0] sampleSet_t;

   logic                              clk;
   logic                              rst;
   sampleSet_t                        samples;
   logic                              sampleValid;
   logic                              cfgWrite;
   peakPkg::cfgAddr_e                 cfgAddr;
   logic [peakPkg::cfgDataWidth-1:0]  cfgWdata;
   logic [peakPkg::cfgDataWidth-1:0]  cfgRdata;
   peakPkg::peak_t                    peak;
   logic                              peakValid;

   peakPkg::peak_t   expQ [$];        // results still in flight
   logic [2:0]       validHist;       // strobes seen by the DUT, newest in bit 0
   logic [31:0]      rngState;
   peakPkg::value_t  modelThreshold;
   logic             modelEnable;
   int               expHits;
   int               errors;
   int               checks;
   string            testName;
   peakPkg::value_t  minValue;

   peakSearchTop u_peakSearchTop
   (
      .clk         (clk),
      .rst         (rst),
      .samples     (samples),
      .sampleValid (sampleValid),
      .cfgWrite    (cfgWrite),
      .cfgAddr     (cfgAddr),
      .cfgWdata    (cfgWdata),
      .cfgRdata    (cfgRdata),
      .peak        (peak),
      .peakValid   (peakValid)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #5 clk = ~clk;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic sampleSet_t randomSet(input logic forceNegative);
      sampleSet_t s;
      for (int i = 0; i < peakPkg::numBins; i++)
      begin
         rngState = xorshift(rngState);
         s[i] = rngState[peakPkg::valueWidth-1:0];
         if (forceNegative)
         begin
            s[i][peakPkg::valueWidth-1] = 1'b1;
         end
      end
      return s;
   endfunction

   function automatic sampleSet_t filledSet(input peakPkg::value_t v);
      sampleSet_t s;
      for (int i = 0; i < peakPkg::numBins; i++)
      begin
         s[i] = v;
      end
      return s;
   endfunction

   // lone value in one bin, all others at the floor
   function automatic sampleSet_t setWithPeak(input int bin, input peakPkg::value_t v);
      sampleSet_t s;
      s = filledSet(minValue);
      s[bin] = v;
      return s;
   endfunction

   // largest signed value, highest bin on a tie, hit when strictly above threshold
   function automatic peakPkg::peak_t refPeak(input sampleSet_t s, input peakPkg::value_t thr,
                                              input logic en);
      peakPkg::peak_t  p;
      peakPkg::value_t best;
      peakPkg::value_t v;
      int              bestIdx;
      best    = s[0];
      bestIdx = 0;
      for (int i = 1; i < peakPkg::numBins; i++)
      begin
         v = s[i];
         if (v >= best)
         begin
            best    = v;
            bestIdx = i;
         end
      end
      p.value = best;
      p.index = peakPkg::indexWidth'(bestIdx);
      p.hit   = en && (best > thr);
      return p;
   endfunction

   task automatic sendSet(input sampleSet_t s);
      peakPkg::peak_t e;
      e = refPeak(s, modelThreshold, modelEnable);
      if (e.hit)
      begin
         expHits++;
      end
      expQ.push_back(e);
      samples     = s;
      sampleValid = 1'b1;
      @(posedge clk);
      #1;
      sampleValid = 1'b0;
   endtask

   task automatic waitIdle();
      int n;
      n = 0;
      while ((expQ.size() != 0 || validHist != 3'b000) && n < 10)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (expQ.size() != 0)
      begin
         $display("%s: %0d results never arrived", testName, expQ.size());
         errors++;
         expQ.delete();
      end
   endtask

   task automatic writeReg(input peakPkg::cfgAddr_e a, input logic [15:0] d);
      cfgWrite = 1'b1;
      cfgAddr  = a;
      cfgWdata = d;
      @(posedge clk);
      #1;
      cfgWrite = 1'b0;
      if (a == peakPkg::addrThreshold)
      begin
         modelThreshold = d[peakPkg::valueWidth-1:0];
      end
      else if (a == peakPkg::addrControl)
      begin
         modelEnable = d[0];
         if (d[1])
         begin
            expHits = 0;   // clear pulse
         end
      end
   endtask

   task automatic checkRead(input peakPkg::cfgAddr_e a, input logic [15:0] expected);
      cfgAddr = a;
      @(negedge clk);
      checks++;
      if (cfgRdata !== expected)
      begin
         $display("Fail %s: register %s expected 0x%04h actual 0x%04h",
                  testName, a.name(), expected, cfgRdata);
         errors++;
      end
      @(posedge clk);
      #1;
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk)
   begin : monitor
      peakPkg::peak_t e;
      if (peakValid !== validHist[2])
      begin
         $display("Fail %s: peakValid expected %b actual %b",
                  testName, validHist[2], peakValid);
         errors++;
      end
      if (peakValid === 1'b1)
      begin
         if (expQ.size() == 0)
         begin
            $display("%s: peakValid seen with no result expected", testName);
            errors++;
         end
         else
         begin
            e = expQ.pop_front();
            checks++;
            if (peak !== e)
            begin
               $display("Fail %s: expected %0d bin %0d hit %0b, actual %0d bin %0d hit %0b",
                        testName, e.value, e.index, e.hit, peak.value, peak.index, peak.hit);
               errors++;
            end
         end
      end
      if (rst)
      begin
         validHist = 3'b000;   // everything in flight is lost
         expQ.delete();
      end
      else
      begin
         validHist = {validHist[1:0], sampleValid};
      end
   end

   task automatic singlePeakSweep();
      testName = "singlePeaks";
      for (int b = 0; b < peakPkg::numBins; b++)
      begin
         sendSet(setWithPeak(b, peakPkg::value_t'(100 + 10 * b)));
         waitIdle();
      end
   endtask

   task automatic signedOrdering();
      sampleSet_t s;
      testName = "ordering";
      for (int i = 0; i < 3; i++)
      begin
         sendSet(randomSet(1'b1));   // all negative
      end
      s = filledSet(-12'sd500);
      s[6] = -12'sd3;
      sendSet(s);
      for (int i = 0; i < 3; i++)
      begin
         sendSet(randomSet(1'b0));   // mixed signs
      end
      s = filledSet(-12'sd1);
      s[3] = 12'sd1;
      sendSet(s);
      s = setWithPeak(2, 12'sd300);   // ties across groups
      s[7]  = 12'sd300;
      s[11] = 12'sd300;
      sendSet(s);
      sendSet(filledSet(12'sd0));
      s = filledSet(-12'sd7);   // tie inside one group
      s[4] = 12'sd9;
      s[5] = 12'sd9;
      sendSet(s);
      waitIdle();
   endtask

   task automatic backToBackSets();
      testName = "throughput";
      for (int i = 0; i < 40; i++)
      begin
         sendSet(randomSet(1'b0));
      end
      waitIdle();
   endtask

   task automatic thresholdAndEnable();
      testName = "threshold";
      writeReg(peakPkg::addrThreshold, 16'h0F9C);   // -100 in 12 bits
      checkRead(peakPkg::addrThreshold, 16'hFF9C);
      sendSet(setWithPeak(5, -12'sd100));
      sendSet(setWithPeak(9, -12'sd99));
      waitIdle();
      writeReg(peakPkg::addrThreshold, 16'd500);
      checkRead(peakPkg::addrThreshold, 16'd500);
      sendSet(setWithPeak(0, 12'sd500));
      sendSet(setWithPeak(15, 12'sd501));
      waitIdle();
      writeReg(peakPkg::addrControl, 16'h0000);
      checkRead(peakPkg::addrControl, 16'h0000);
      sendSet(setWithPeak(7, 12'sd2000));
      waitIdle();
      writeReg(peakPkg::addrControl, 16'h0001);
      checkRead(peakPkg::addrControl, 16'h0001);
   endtask

   task automatic hitCountAndClear();
      testName = "hitCounter";
      writeReg(peakPkg::addrThreshold, 16'd0);
      writeReg(peakPkg::addrControl, 16'h0003);   // enable and clear
      checkRead(peakPkg::addrHitCount, 16'h0000);
      for (int i = 0; i < 12; i++)
      begin
         if (i % 3 == 0)
         begin
            sendSet(randomSet(1'b1));   // never above zero
         end
         else
         begin
            sendSet(setWithPeak(i, peakPkg::value_t'(200 + i)));
         end
      end
      waitIdle();
      checkRead(peakPkg::addrHitCount, 16'(expHits));
      writeReg(peakPkg::addrControl, 16'h0003);
      checkRead(peakPkg::addrHitCount, 16'h0000);
   endtask

   task automatic resetMidStream();
      testName = "resetMidStream";
      sendSet(setWithPeak(4, 12'sd100));   // leaves a nonzero count behind
      waitIdle();
      writeReg(peakPkg::addrThreshold, 16'h0123);
      writeReg(peakPkg::addrControl, 16'h0000);
      sendSet(randomSet(1'b0));
      sendSet(randomSet(1'b0));
      rst = 1'b1;
      repeat (2)
      begin
         @(posedge clk);
      end
      #1;
      rst            = 1'b0;
      modelThreshold = '0;
      modelEnable    = 1'b1;
      expHits        = 0;
      repeat (5)
      begin
         @(posedge clk);   // monitor flags any stray peakValid
      end
      #1;
      checkRead(peakPkg::addrThreshold, 16'h0000);
      checkRead(peakPkg::addrControl, 16'h0001);
      checkRead(peakPkg::addrHitCount, 16'h0000);
   endtask

   initial
   begin : watchdog
      int limit;
      limit = 5 + 16 * 6 + 12 * 6 + 50 + 70 + 80 + 40;   // reset then each test
      limit = limit + 200;
      repeat (limit)
      begin
         @(posedge clk);
      end
      $display("watchdog: run did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
   end

   initial
   begin
      rst            = 1'b1;
      samples        = '0;
      sampleValid    = 1'b0;
      cfgWrite       = 1'b0;
      cfgAddr        = peakPkg::addrThreshold;
      cfgWdata       = '0;
      validHist      = 3'b000;
      rngState       = 32'd31;
      modelThreshold = '0;
      modelEnable    = 1'b1;
      expHits        = 0;
      errors         = 0;
      checks         = 0;
      testName       = "reset";
      minValue       = {1'b1, {(peakPkg::valueWidth - 1){1'b0}}};   // most negative
      repeat (5)
      begin
         @(posedge clk);
      end
      #1;
      rst = 1'b0;
      singlePeakSweep();
      signedOrdering();
      backToBackSets();
      thresholdAndEnable();
      hitCountAndClear();
      resetMidStream();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
rtl/peakPkg.sv
rtl/maxOf4.sv
rtl/peakTree.sv
rtl/peakDetect.sv
rtl/peakCfg.sv
rtl/peakSearchTop.sv
verif/peakSearchTb.sv
